// File: source/calc_pkg.sv
`default_nettype none

package calc_pkg;

	localparam int DATA_W    = 32;
	localparam int CMD_W     = 4;
	localparam int RESP_W    = 2;
	localparam int NUM_PORTS = 4;
	localparam int PORT_ID_W = 2;
	localparam int SHAMT_W   = 5;

	// external command codes, anything not listed here is invalid
	typedef enum logic [CMD_W-1:0] {
		CMD_NOP = 4'd0,
		CMD_ADD = 4'd1,
		CMD_SUB = 4'd2,
		CMD_SHL = 4'd5,
		CMD_SHR = 4'd6
	} cmd_e;

	typedef enum logic [RESP_W-1:0] {
		RESP_NONE    = 2'd0,
		RESP_OK      = 2'd1,
		RESP_OVFL    = 2'd2,	// overflow or underflow
		RESP_BAD_CMD = 2'd3
	} resp_e;

	// decoded operation, also selects the execution unit
	typedef enum logic [1:0] {
		OP_ADD,
		OP_SUB,
		OP_SHL,
		OP_SHR
	} op_kind_e;

	typedef struct packed {
		logic [DATA_W-SHAMT_W-1:0] pad;	// ignored by the shifter
		logic [SHAMT_W-1:0]        shamt;
	} shift_op_t;

	// operand 2 is a full word for add/sub and a shift amount for shifts
	typedef union packed {
		logic [DATA_W-1:0] word;
		shift_op_t         sh;
	} operand2_u;

endpackage

`default_nettype wire

// File: source/calc_if.sv
`timescale 1ns/1ps
`default_nettype none

// one request from a port front end towards the arbiter
interface port_req_if import calc_pkg::*; ();
	logic              pending;
	op_kind_e          op_kind;
	logic [DATA_W-1:0] op1;
	operand2_u         op2;
	logic              grant;

	modport front (output pending, op_kind, op1, op2, input grant);
	modport arb (input pending, op_kind, op1, op2, output grant);
endinterface

// arbiter to execution unit, credit returns on pop
interface dispatch_if import calc_pkg::*; ();
	logic                 valid;
	logic [PORT_ID_W-1:0] port_id;
	op_kind_e             op_kind;
	logic [DATA_W-1:0]    op1;
	operand2_u            op2;
	logic                 credit;

	modport arb (output valid, port_id, op_kind, op1, op2, input credit);
	modport unit (input valid, port_id, op_kind, op1, op2, output credit);
endinterface

// result broadcast, every port front filters on port_id
interface result_if import calc_pkg::*; ();
	logic                 valid;
	logic [PORT_ID_W-1:0] port_id;
	resp_e                resp;
	logic [DATA_W-1:0]    data;

	modport unit (output valid, port_id, resp, data);
	modport port (input valid, port_id, resp, data);
endinterface

`default_nettype wire

// File: source/port_front.sv
`timescale 1ns/1ps
`default_nettype none

module port_front import calc_pkg::*; #(
	parameter logic [PORT_ID_W-1:0] PORT_ID = '0
) (
	input  logic              c_clk,
	input  logic              rst_n,
	input  logic [CMD_W-1:0]  cmd,
	input  logic [DATA_W-1:0] data,
	port_req_if.front         req,
	result_if.port            res_as,
	result_if.port            res_sh,
	output resp_e             resp,
	output logic [DATA_W-1:0] resp_data
);

	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_OP2  = 2'd1;	// operand 2 on data this cycle
	localparam logic [1:0] S_PEND = 2'd2;	// waiting for a grant
	localparam logic [1:0] S_WAIT = 2'd3;	// dispatched, waiting for result

	logic [1:0]        state;
	logic [CMD_W-1:0]  cmd_q;
	logic [DATA_W-1:0] op1_q;
	operand2_u         op2_q;
	op_kind_e          kind_q;
	op_kind_e          kind_d;
	logic              bad_cmd;
	logic              hit_as;
	logic              hit_sh;

	always_comb begin
		bad_cmd = 1'b0;
		kind_d  = OP_ADD;
		case (cmd_q)
			CMD_ADD: kind_d = OP_ADD;
			CMD_SUB: kind_d = OP_SUB;
			CMD_SHL: kind_d = OP_SHL;
			CMD_SHR: kind_d = OP_SHR;
			default: bad_cmd = 1'b1;
		endcase
	end

	assign hit_as = res_as.valid && (res_as.port_id == PORT_ID);
	assign hit_sh = res_sh.valid && (res_sh.port_id == PORT_ID);

	always_ff @(posedge c_clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= S_IDLE;
			resp      <= RESP_NONE;
			resp_data <= '0;
		end else begin
			resp      <= RESP_NONE;	// response lasts one cycle
			resp_data <= '0;
			case (state)
				S_IDLE: begin
					if (cmd != CMD_NOP)
						state <= S_OP2;
				end
				S_OP2: begin
					if (bad_cmd) begin
						state <= S_IDLE;
						resp  <= RESP_BAD_CMD;	// answered locally, never dispatched
					end else begin
						state <= S_PEND;
					end
				end
				S_PEND: begin
					if (req.grant)
						state <= S_WAIT;
				end
				default: begin
					if (hit_as) begin
						state     <= S_IDLE;
						resp      <= res_as.resp;
						resp_data <= res_as.data;
					end else if (hit_sh) begin
						state     <= S_IDLE;
						resp      <= res_sh.resp;
						resp_data <= res_sh.data;
					end
				end
			endcase
		end
	end

	always_ff @(posedge c_clk) begin
		if (state == S_IDLE) begin
			cmd_q <= cmd;
			op1_q <= data;
		end
		if (state == S_OP2) begin
			op2_q  <= operand2_u'(data);
			kind_q <= kind_d;
		end
	end

	assign req.pending = (state == S_PEND);
	assign req.op_kind = kind_q;
	assign req.op1     = op1_q;
	assign req.op2     = op2_q;

endmodule

`default_nettype wire

// File: source/dispatch_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch_arbiter import calc_pkg::*; #(
	parameter int QUEUE_DEPTH = 2
) (
	input  logic     c_clk,
	input  logic     rst_n,
	port_req_if.arb  ports [NUM_PORTS],
	dispatch_if.arb  to_as,
	dispatch_if.arb  to_sh
);

	localparam int NUM_UNITS = 2;	// 0 is add/sub, 1 is shift
	localparam int CNT_W     = $clog2(QUEUE_DEPTH + 1);

	logic [NUM_PORTS-1:0] pend;
	logic [NUM_PORTS-1:0] for_sh;
	logic [NUM_PORTS-1:0] grant_d;
	logic [NUM_PORTS-1:0] grant_q;
	op_kind_e             kind [NUM_PORTS];
	logic [DATA_W-1:0]    op1 [NUM_PORTS];
	operand2_u            op2 [NUM_PORTS];

	logic [NUM_UNITS-1:0] hit;
	logic [NUM_UNITS-1:0] go;
	logic [NUM_UNITS-1:0] vld_q;
	logic [NUM_UNITS-1:0] credit;
	logic [CNT_W-1:0]     credit_cnt [NUM_UNITS];
	logic [PORT_ID_W-1:0] sel [NUM_UNITS];
	logic [PORT_ID_W-1:0] pid_q [NUM_UNITS];
	op_kind_e             kind_q [NUM_UNITS];
	logic [DATA_W-1:0]    op1_q [NUM_UNITS];
	operand2_u            op2_q [NUM_UNITS];

	for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
		assign pend[i]        = ports[i].pending;
		assign kind[i]        = ports[i].op_kind;
		assign op1[i]         = ports[i].op1;
		assign op2[i]         = ports[i].op2;
		assign for_sh[i]      = (kind[i] == OP_SHL) || (kind[i] == OP_SHR);
		assign ports[i].grant = grant_q[i];
	end

	// lowest pending port wins, a port granted this cycle is still pending
	always_comb begin
		for (int u = 0; u < NUM_UNITS; u++) begin
			hit[u] = 1'b0;
			sel[u] = '0;
			for (int i = NUM_PORTS - 1; i >= 0; i--) begin
				if (pend[i] && !grant_q[i] && (for_sh[i] == (u == 1))) begin
					hit[u] = 1'b1;
					sel[u] = PORT_ID_W'(i);
				end
			end
			go[u] = hit[u] && (credit_cnt[u] > CNT_W'(vld_q[u]));	// valid in flight holds a credit
		end
		for (int i = 0; i < NUM_PORTS; i++) begin
			grant_d[i] = (go[0] && (sel[0] == PORT_ID_W'(i))) ||
			             (go[1] && (sel[1] == PORT_ID_W'(i)));
		end
	end

	always_ff @(posedge c_clk or negedge rst_n) begin
		if (!rst_n) begin
			grant_q <= '0;
			vld_q   <= '0;
			for (int u = 0; u < NUM_UNITS; u++)
				credit_cnt[u] <= CNT_W'(QUEUE_DEPTH);
		end else begin
			grant_q <= grant_d;
			vld_q   <= go;
			for (int u = 0; u < NUM_UNITS; u++)
				credit_cnt[u] <= credit_cnt[u] - CNT_W'(vld_q[u]) + CNT_W'(credit[u]);
		end
	end

	always_ff @(posedge c_clk) begin
		for (int u = 0; u < NUM_UNITS; u++) begin
			if (go[u]) begin
				pid_q[u]  <= sel[u];
				kind_q[u] <= kind[sel[u]];
				op1_q[u]  <= op1[sel[u]];
				op2_q[u]  <= op2[sel[u]];
			end
		end
	end

	assign credit[0]     = to_as.credit;
	assign credit[1]     = to_sh.credit;
	assign to_as.valid   = vld_q[0];
	assign to_as.port_id = pid_q[0];
	assign to_as.op_kind = kind_q[0];
	assign to_as.op1     = op1_q[0];
	assign to_as.op2     = op2_q[0];
	assign to_sh.valid   = vld_q[1];
	assign to_sh.port_id = pid_q[1];
	assign to_sh.op_kind = kind_q[1];
	assign to_sh.op1     = op1_q[1];
	assign to_sh.op2     = op2_q[1];

endmodule

`default_nettype wire

// File: source/add_sub_unit.sv
`timescale 1ns/1ps
`default_nettype none

module add_sub_unit import calc_pkg::*; #(
	parameter int QUEUE_DEPTH = 2
) (
	input  logic     c_clk,
	input  logic     rst_n,
	dispatch_if.unit cmd_in,
	result_if.unit   res
);

	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	logic [PORT_ID_W-1:0] q_pid [QUEUE_DEPTH];
	op_kind_e             q_kind [QUEUE_DEPTH];
	logic [DATA_W-1:0]    q_op1 [QUEUE_DEPTH];
	operand2_u            q_op2 [QUEUE_DEPTH];
	logic [PTR_W-1:0]     wr_ptr;
	logic [PTR_W-1:0]     rd_ptr;
	logic [CNT_W-1:0]     count;
	logic                 pop;
	logic [DATA_W-1:0]    a;
	logic [DATA_W-1:0]    b;
	logic [DATA_W:0]      sum;
	logic                 ovfl;
	logic [DATA_W-1:0]    result;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign pop           = (count != '0);	// head is served every cycle
	assign cmd_in.credit = pop;

	always_ff @(posedge c_clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (cmd_in.valid)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			count <= count + CNT_W'(cmd_in.valid) - CNT_W'(pop);
		end
	end

	always_ff @(posedge c_clk) begin
		if (cmd_in.valid) begin
			q_pid[wr_ptr]  <= cmd_in.port_id;
			q_kind[wr_ptr] <= cmd_in.op_kind;
			q_op1[wr_ptr]  <= cmd_in.op1;
			q_op2[wr_ptr]  <= cmd_in.op2;
		end
	end

	assign a   = q_op1[rd_ptr];
	assign b   = q_op2[rd_ptr].word;
	assign sum = {1'b0, a} + {1'b0, b};

	always_comb begin
		if (q_kind[rd_ptr] == OP_SUB) begin
			ovfl   = (a < b);	// unsigned underflow
			result = a - b;
		end else begin
			ovfl   = sum[DATA_W];	// carry out
			result = sum[DATA_W-1:0];
		end
	end

	always_ff @(posedge c_clk or negedge rst_n) begin
		if (!rst_n)
			res.valid <= 1'b0;
		else
			res.valid <= pop;
	end

	always_ff @(posedge c_clk) begin
		if (pop) begin
			res.port_id <= q_pid[rd_ptr];
			res.resp    <= ovfl ? RESP_OVFL : RESP_OK;
			res.data    <= ovfl ? '0 : result;
		end
	end

endmodule

`default_nettype wire

// File: source/shift_unit.sv
`timescale 1ns/1ps
`default_nettype none

module shift_unit import calc_pkg::*; #(
	parameter int QUEUE_DEPTH = 2
) (
	input  logic     c_clk,
	input  logic     rst_n,
	dispatch_if.unit cmd_in,
	result_if.unit   res
);

	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	logic [PORT_ID_W-1:0] q_pid [QUEUE_DEPTH];
	op_kind_e             q_kind [QUEUE_DEPTH];
	logic [DATA_W-1:0]    q_op1 [QUEUE_DEPTH];
	operand2_u            q_op2 [QUEUE_DEPTH];
	logic [PTR_W-1:0]     wr_ptr;
	logic [PTR_W-1:0]     rd_ptr;
	logic [CNT_W-1:0]     count;
	logic                 pop;
	logic [SHAMT_W-1:0]   shamt;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign pop           = (count != '0);
	assign cmd_in.credit = pop;

	always_ff @(posedge c_clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (cmd_in.valid)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			count <= count + CNT_W'(cmd_in.valid) - CNT_W'(pop);
		end
	end

	always_ff @(posedge c_clk) begin
		if (cmd_in.valid) begin
			q_pid[wr_ptr]  <= cmd_in.port_id;
			q_kind[wr_ptr] <= cmd_in.op_kind;
			q_op1[wr_ptr]  <= cmd_in.op1;
			q_op2[wr_ptr]  <= cmd_in.op2;
		end
	end

	assign shamt = q_op2[rd_ptr].sh.shamt;	// upper 27 bits never matter

	always_ff @(posedge c_clk or negedge rst_n) begin
		if (!rst_n)
			res.valid <= 1'b0;
		else
			res.valid <= pop;
	end

	// logical shifts only, no error case
	always_ff @(posedge c_clk) begin
		if (pop) begin
			res.port_id <= q_pid[rd_ptr];
			res.resp    <= RESP_OK;
			if (q_kind[rd_ptr] == OP_SHL)
				res.data <= q_op1[rd_ptr] << shamt;
			else
				res.data <= q_op1[rd_ptr] >> shamt;
		end
	end

endmodule

`default_nettype wire

// File: source/calc_top.sv
`timescale 1ns/1ps
`default_nettype none

module calc_top import calc_pkg::*; #(
	parameter int QUEUE_DEPTH = 2
) (
	input  logic              c_clk,
	input  logic              rst_n,
	input  logic [CMD_W-1:0]  req1_cmd,
	input  logic [DATA_W-1:0] req1_data,
	input  logic [CMD_W-1:0]  req2_cmd,
	input  logic [DATA_W-1:0] req2_data,
	input  logic [CMD_W-1:0]  req3_cmd,
	input  logic [DATA_W-1:0] req3_data,
	input  logic [CMD_W-1:0]  req4_cmd,
	input  logic [DATA_W-1:0] req4_data,
	output logic [RESP_W-1:0] resp1,
	output logic [DATA_W-1:0] data1,
	output logic [RESP_W-1:0] resp2,
	output logic [DATA_W-1:0] data2,
	output logic [RESP_W-1:0] resp3,
	output logic [DATA_W-1:0] data3,
	output logic [RESP_W-1:0] resp4,
	output logic [DATA_W-1:0] data4
);

	port_req_if req_if [NUM_PORTS] ();
	dispatch_if as_disp ();
	dispatch_if sh_disp ();
	result_if   as_res ();
	result_if   sh_res ();

	port_front #(.PORT_ID(PORT_ID_W'(0))) u_port1 (
		.c_clk, .rst_n, .cmd(req1_cmd), .data(req1_data), .req(req_if[0]),
		.res_as(as_res), .res_sh(sh_res), .resp(resp1), .resp_data(data1));

	port_front #(.PORT_ID(PORT_ID_W'(1))) u_port2 (
		.c_clk, .rst_n, .cmd(req2_cmd), .data(req2_data), .req(req_if[1]),
		.res_as(as_res), .res_sh(sh_res), .resp(resp2), .resp_data(data2));

	port_front #(.PORT_ID(PORT_ID_W'(2))) u_port3 (
		.c_clk, .rst_n, .cmd(req3_cmd), .data(req3_data), .req(req_if[2]),
		.res_as(as_res), .res_sh(sh_res), .resp(resp3), .resp_data(data3));

	port_front #(.PORT_ID(PORT_ID_W'(3))) u_port4 (
		.c_clk, .rst_n, .cmd(req4_cmd), .data(req4_data), .req(req_if[3]),
		.res_as(as_res), .res_sh(sh_res), .resp(resp4), .resp_data(data4));

	dispatch_arbiter #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_arb (
		.c_clk, .rst_n, .ports(req_if), .to_as(as_disp), .to_sh(sh_disp));

	add_sub_unit #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_add_sub (
		.c_clk, .rst_n, .cmd_in(as_disp), .res(as_res));

	shift_unit #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_shift (
		.c_clk, .rst_n, .cmd_in(sh_disp), .res(sh_res));

endmodule

`default_nettype wire

// File: dv/calc_checker.sv
`timescale 1ns/1ps
`default_nettype none

// protocol checks on the calculator, bound into calc_top
// the credit counters are read from the arbiter instance inside it
module calc_checker import calc_pkg::*; #(
	parameter int QUEUE_DEPTH = 2,
	parameter int CNT_W       = $clog2(QUEUE_DEPTH + 1)
) (
	input logic              c_clk,
	input logic              rst_n,
	input logic              as_valid,
	input logic              sh_valid,
	input logic [CNT_W-1:0]  as_cnt,
	input logic [CNT_W-1:0]  sh_cnt,
	input logic [RESP_W-1:0] resp1,
	input logic [RESP_W-1:0] resp2,
	input logic [RESP_W-1:0] resp3,
	input logic [RESP_W-1:0] resp4
);

	logic [RESP_W-1:0] resp_all [NUM_PORTS];

	assign resp_all[0] = resp1;
	assign resp_all[1] = resp2;
	assign resp_all[2] = resp3;
	assign resp_all[3] = resp4;

	a_as_credit: assert property (@(posedge c_clk) disable iff (!rst_n)
		as_valid |-> as_cnt != '0)
		else $error("add/sub dispatch issued with no credit left");

	a_sh_credit: assert property (@(posedge c_clk) disable iff (!rst_n)
		sh_valid |-> sh_cnt != '0)
		else $error("shift dispatch issued with no credit left");

	// counters start full and may never grow past the queue depth
	a_cnt_max: assert property (@(posedge c_clk) disable iff (!rst_n)
		(as_cnt <= CNT_W'(QUEUE_DEPTH)) && (sh_cnt <= CNT_W'(QUEUE_DEPTH)))
		else $error("credit counter above queue depth");

	for (genvar i = 0; i < NUM_PORTS; i++) begin : g_resp
		a_resp_pulse: assert property (@(posedge c_clk) disable iff (!rst_n)
			resp_all[i] != '0 |=> resp_all[i] == '0)
			else $error("response on port %0d held for more than one cycle", i + 1);

		a_resp_reset: assert property (@(posedge c_clk)
			(!rst_n && !$past(rst_n)) |-> resp_all[i] == '0)
			else $error("response on port %0d not idle during reset", i + 1);
	end

endmodule

bind calc_top calc_checker #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_checker (
	.c_clk,
	.rst_n,
	.as_valid(as_disp.valid),
	.sh_valid(sh_disp.valid),
	.as_cnt(u_arb.credit_cnt[0]),
	.sh_cnt(u_arb.credit_cnt[1]),
	.resp1,
	.resp2,
	.resp3,
	.resp4
);

`default_nettype wire

// File: dv/calc_tb.sv
`timescale 1ns/1ps
`default_nettype none

module calc_tb import calc_pkg::*; ();

	localparam int TIMEOUT = 20;	// cycles allowed per response
	localparam int ROUNDS  = 60;

	logic              c_clk;
	logic              rst_n;
	logic [CMD_W-1:0]  req_cmd [NUM_PORTS];
	logic [DATA_W-1:0] req_data [NUM_PORTS];
	logic [RESP_W-1:0] resp [NUM_PORTS];
	logic [DATA_W-1:0] rdata [NUM_PORTS];

	// command staged per port and its expected answer
	logic [CMD_W-1:0]  cmd_v [NUM_PORTS];
	logic [DATA_W-1:0] op1_v [NUM_PORTS];
	logic [DATA_W-1:0] op2_v [NUM_PORTS];
	logic [RESP_W-1:0] exp_resp [NUM_PORTS];
	logic [DATA_W-1:0] exp_data [NUM_PORTS];
	logic [31:0]       lfsr;

	calc_top #(.QUEUE_DEPTH(2)) uut (
		.c_clk,
		.rst_n,
		.req1_cmd(req_cmd[0]), .req1_data(req_data[0]),
		.req2_cmd(req_cmd[1]), .req2_data(req_data[1]),
		.req3_cmd(req_cmd[2]), .req3_data(req_data[2]),
		.req4_cmd(req_cmd[3]), .req4_data(req_data[3]),
		.resp1(resp[0]), .data1(rdata[0]),
		.resp2(resp[1]), .data2(rdata[1]),
		.resp3(resp[2]), .data3(rdata[2]),
		.resp4(resp[3]), .data4(rdata[3])
	);

	always #20 c_clk = ~c_clk;

	// Fibonacci LFSR on x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		logic        fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v    = {v[30:0], fb};
		end
		return v;
	endfunction

	// expected answer of one command
	function automatic void model_op(input logic [CMD_W-1:0] cmd,
			input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b,
			output logic [RESP_W-1:0] r, output logic [DATA_W-1:0] d);
		r = RESP_OK;
		d = '0;
		case (cmd)
			CMD_NOP: r = RESP_NONE;
			CMD_ADD: begin
				if (a > ~b)	// sum would pass all ones
					r = RESP_OVFL;
				else
					d = a + b;
			end
			CMD_SUB: begin
				if (a < b)
					r = RESP_OVFL;
				else
					d = a - b;
			end
			CMD_SHL: d = a << b[SHAMT_W-1:0];	// low 5 bits only
			CMD_SHR: d = a >> b[SHAMT_W-1:0];
			default: r = RESP_BAD_CMD;
		endcase
	endfunction

	task automatic stop_with_error();
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic clear_ops();
		for (int p = 0; p < NUM_PORTS; p++) begin
			cmd_v[p] = CMD_NOP;
			op1_v[p] = '0;
			op2_v[p] = '0;
			model_op(CMD_NOP, '0, '0, exp_resp[p], exp_data[p]);
		end
	endtask

	task automatic set_op(input int p, input logic [CMD_W-1:0] cmd,
			input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
		cmd_v[p] = cmd;
		op1_v[p] = a;
		op2_v[p] = b;
		model_op(cmd, a, b, exp_resp[p], exp_data[p]);
	endtask

	task automatic expect_idle();
		for (int p = 0; p < NUM_PORTS; p++) begin
			assert (resp[p] == RESP_NONE) else begin
				$display("port %0d gave a response when none was due at %0t", p + 1, $time);
				stop_with_error();
			end
		end
	endtask

	// command with operand 1 and operand 2 one cycle later
	task automatic issue_round();
		@(negedge c_clk);
		expect_idle();
		for (int p = 0; p < NUM_PORTS; p++) begin
			req_cmd[p]  = cmd_v[p];
			req_data[p] = op1_v[p];
		end
		@(negedge c_clk);
		expect_idle();
		for (int p = 0; p < NUM_PORTS; p++) begin
			req_cmd[p]  = CMD_NOP;
			req_data[p] = op2_v[p];
		end
		@(negedge c_clk);
		for (int p = 0; p < NUM_PORTS; p++)
			req_data[p] = '0;
	endtask

	task automatic collect_responses();
		logic [NUM_PORTS-1:0] done;
		int                   waited;
		for (int p = 0; p < NUM_PORTS; p++)
			done[p] = (cmd_v[p] == CMD_NOP);
		waited = 0;
		forever begin
			for (int p = 0; p < NUM_PORTS; p++) begin
				if (resp[p] != RESP_NONE) begin
					if (done[p]) begin
						$display("port %0d answered with no command outstanding at %0t",
							p + 1, $time);
						stop_with_error();
					end
					assert (resp[p] == exp_resp[p] && rdata[p] == exp_data[p]) else begin
						$display("MISMATCH at %0t: port %0d resp %0d data %h, expected %0d %h",
							$time, p + 1, resp[p], rdata[p], exp_resp[p], exp_data[p]);
						stop_with_error();
					end
					done[p] = 1'b1;
				end
			end
			if (&done)
				break;
			if (waited == TIMEOUT) begin
				$display("no response within %0d cycles, ports waiting %b", TIMEOUT, ~done);
				stop_with_error();
			end
			waited++;
			@(negedge c_clk);
		end
	endtask

	task automatic check_quiet(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			expect_idle();
			@(negedge c_clk);
		end
	endtask

	task automatic single_op(input int p, input logic [CMD_W-1:0] cmd,
			input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
		clear_ops();
		set_op(p, cmd, a, b);
		issue_round();
		collect_responses();
	endtask

	task automatic random_round();
		logic [1:0]        pick;
		logic [CMD_W-1:0]  cmd;
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
		for (int p = 0; p < NUM_PORTS; p++) begin
			pick = 2'(rand_bits(2));
			case (pick)
				2'd0: cmd = CMD_ADD;
				2'd1: cmd = CMD_SUB;
				2'd2: cmd = CMD_SHL;
				default: cmd = CMD_SHR;
			endcase
			if (rand_bits(3) == 32'd0)
				cmd = 4'd7 + 4'(rand_bits(3));	// invalid codes 7 to 14
			a = rand_bits(DATA_W);
			b = rand_bits(DATA_W);
			set_op(p, cmd, a, b);
		end
	endtask

	initial begin
		c_clk = 1'b0;
		rst_n = 1'b0;
		lfsr  = 32'hbb2b_0522;
		for (int p = 0; p < NUM_PORTS; p++) begin
			req_cmd[p]  = CMD_NOP;
			req_data[p] = '0;
		end
		clear_ops();
		repeat (16) @(posedge c_clk);
		@(negedge c_clk);
		rst_n = 1'b1;
		check_quiet(4);	// idle after reset

		for (int p = 0; p < NUM_PORTS; p++) begin
			single_op(p, CMD_ADD, 32'd100, 32'd23);
			single_op(p, CMD_SUB, 32'd1000, 32'd1);
			single_op(p, CMD_SHL, 32'h0000_00a5, 32'd4);
			single_op(p, CMD_SHR, 32'hf000_0000, 32'd8);
			single_op(p, CMD_ADD, 32'hffff_ffff, 32'd1);	// overflow by one
			single_op(p, CMD_ADD, 32'h8000_0000, 32'h8000_0000);
			single_op(p, CMD_ADD, 32'hffff_0000, 32'h0000_ffff);	// exactly all ones
			single_op(p, CMD_SUB, 32'd5, 32'd6);	// underflow by one
			single_op(p, CMD_SUB, 32'h1234_5678, 32'h1234_5678);
			single_op(p, 4'd3, 32'd1, 32'd2);
			single_op(p, 4'd4, 32'd1, 32'd2);
			single_op(p, 4'd15, 32'd1, 32'd2);
		end

		// no-op with data on the bus must stay silent
		single_op(1, CMD_NOP, 32'hdead_beef, 32'h0000_0001);
		check_quiet(TIMEOUT);

		// shift amount is op2[4:0]
		single_op(0, CMD_SHL, 32'h0000_0003, 32'd33);
		single_op(0, CMD_SHL, 32'h0000_0003, 32'd1);
		single_op(2, CMD_SHR, 32'h8000_0000, 32'd33);
		single_op(2, CMD_SHR, 32'h8000_0000, 32'd31);
		single_op(3, CMD_SHL, 32'hcafe_f00d, 32'd0);
		single_op(3, CMD_SHL, 32'h0000_0001, 32'd31);
		single_op(1, CMD_SHR, 32'hcafe_f00d, 32'hffff_ffe0);

		for (int r = 0; r < ROUNDS; r++) begin
			random_round();
			issue_round();
			collect_responses();
		end

		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
source/calc_pkg.sv
source/calc_if.sv
source/port_front.sv
source/dispatch_arbiter.sv
source/add_sub_unit.sv
source/shift_unit.sv
source/calc_top.sv
dv/calc_checker.sv
dv/calc_tb.sv

// File: run.sh
#!/bin/sh
# build and run the calculator testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module calc_tb -f list.f -o calc_sim \
	&& ./obj_dir/calc_sim > sim.log 2>&1 \
	|| echo "build or simulation reported a failure"
grep -q "Finished with no errors" sim.log 2>/dev/null \
	&& ! grep -q "%Error" sim.log \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }
